//--- rvTypesPkg.sv
package rvTypesPkg;

    // one 16-bit parcel as delivered by fetch.
    typedef struct packed {
        logic [15:0] parcel;
        logic [31:0] pc;
        logic [3:0]  branchId;
        logic        branchPred;
        logic        valid;
    } halfEntry_t;

    // assembled instruction, upper half zero when compressed.
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [3:0]  branchId;
        logic        branchPred;
        logic        isRvc;
        logic        valid;
    } pdInstr_t;

    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LOAD   = 3'd1,
        STORE  = 3'd2,
        BRANCH = 3'd3,
        JAL    = 3'd4,
        JALR   = 3'd5,
        SYSTEM = 3'd6,
        OTHER  = 3'd7
    } instrClass_e;

    // result handed to the back end.
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        instrClass_e cls;
        logic        isRvc;
        logic        illegal;
        logic [3:0]  branchId;
        logic        branchPred;
        logic        valid;
    } decInstr_t;

endpackage

//--- frontendCfgPkg.sv
package frontendCfgPkg;

    localparam int NUM_IN = 2;    // halfwords per fetch packet.
    localparam int NUM_OUT = 2;   // instructions per cycle.
    localparam int BUF_SIZE = 16; // power of two, indices wrap.

    // full rises once free entries drop below this.
    localparam int FULL_MARGIN = NUM_IN + 1;

    localparam int IDX_W = $clog2(BUF_SIZE);

    typedef logic [IDX_W-1:0] bufIdx_t;
    typedef logic [IDX_W:0]   bufCnt_t;

endpackage

//--- PreDecode.sv
`timescale 1ns/1ns

module PreDecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mispred,
    input  logic                   fetchValid,
    input  rvTypesPkg::halfEntry_t fetchHalves[frontendCfgPkg::NUM_IN],
    input  logic                   outEn,
    output logic                   full,
    output rvTypesPkg::pdInstr_t   pdSlots[frontendCfgPkg::NUM_OUT]
);

    rvTypesPkg::halfEntry_t buffer[frontendCfgPkg::BUF_SIZE];

    frontendCfgPkg::bufIdx_t inIdx;
    frontendCfgPkg::bufIdx_t outIdx;
    frontendCfgPkg::bufCnt_t freeCnt;

    frontendCfgPkg::bufIdx_t rdIdx;
    frontendCfgPkg::bufIdx_t secIdx;
    frontendCfgPkg::bufCnt_t usedCnt;
    frontendCfgPkg::bufCnt_t popCnt;
    frontendCfgPkg::bufCnt_t pushCnt;
    frontendCfgPkg::bufCnt_t freeNext;
    logic                    stall;

    frontendCfgPkg::bufIdx_t wrAddr[frontendCfgPkg::NUM_IN];
    logic                    wrEn[frontendCfgPkg::NUM_IN];
    rvTypesPkg::pdInstr_t    slotNext[frontendCfgPkg::NUM_OUT];

    // walk the buffer head, one instruction per slot.
    always_comb begin
        rdIdx = outIdx;
        secIdx = outIdx;
        usedCnt = frontendCfgPkg::bufCnt_t'(frontendCfgPkg::BUF_SIZE) - freeCnt;
        popCnt = '0;
        stall = !outEn;
        for (int i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin
            slotNext[i] = '0;
            secIdx = rdIdx + frontendCfgPkg::bufIdx_t'(1);
            if (!stall && usedCnt != '0) begin
                if (buffer[rdIdx].parcel[1:0] == 2'b11) begin
                    if (usedCnt > frontendCfgPkg::bufCnt_t'(1)) begin
                        slotNext[i].instr = {buffer[secIdx].parcel, buffer[rdIdx].parcel};
                        slotNext[i].pc = buffer[rdIdx].pc;
                        slotNext[i].branchId = buffer[secIdx].branchId; // tag of upper half.
                        slotNext[i].branchPred = buffer[secIdx].branchPred;
                        slotNext[i].isRvc = 1'b0;
                        slotNext[i].valid = 1'b1;
                        rdIdx = rdIdx + frontendCfgPkg::bufIdx_t'(2);
                        usedCnt = usedCnt - frontendCfgPkg::bufCnt_t'(2);
                        popCnt = popCnt + frontendCfgPkg::bufCnt_t'(2);
                    end else begin
                        stall = 1'b1; // upper half not fetched yet.
                    end
                end else begin
                    slotNext[i].instr = {16'h0000, buffer[rdIdx].parcel};
                    slotNext[i].pc = buffer[rdIdx].pc;
                    slotNext[i].branchId = buffer[rdIdx].branchId;
                    slotNext[i].branchPred = buffer[rdIdx].branchPred;
                    slotNext[i].isRvc = 1'b1;
                    slotNext[i].valid = 1'b1;
                    rdIdx = rdIdx + frontendCfgPkg::bufIdx_t'(1);
                    usedCnt = usedCnt - frontendCfgPkg::bufCnt_t'(1);
                    popCnt = popCnt + frontendCfgPkg::bufCnt_t'(1);
                end
            end
        end
    end

    // pack valid halves back to back.
    always_comb begin
        pushCnt = '0;
        for (int i = 0; i < frontendCfgPkg::NUM_IN; i++) begin
            wrEn[i] = fetchValid && fetchHalves[i].valid;
            wrAddr[i] = inIdx + frontendCfgPkg::bufIdx_t'(pushCnt);
            if (wrEn[i]) begin
                pushCnt = pushCnt + frontendCfgPkg::bufCnt_t'(1);
            end
        end
        freeNext = freeCnt + popCnt - pushCnt;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < frontendCfgPkg::NUM_IN; i++) begin
            if (wrEn[i]) begin
                buffer[wrAddr[i]] <= fetchHalves[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            inIdx <= '0;
            outIdx <= '0;
            freeCnt <= frontendCfgPkg::bufCnt_t'(frontendCfgPkg::BUF_SIZE);
            full <= 1'b0;
            for (int i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin
                pdSlots[i].valid <= 1'b0;
            end
        end else begin
            inIdx <= inIdx + frontendCfgPkg::bufIdx_t'(pushCnt);
            outIdx <= rdIdx;
            freeCnt <= freeNext;
            full <= freeNext < frontendCfgPkg::bufCnt_t'(frontendCfgPkg::FULL_MARGIN);
            pdSlots <= slotNext; // valids low when outEn is low.
        end
    end

endmodule

//--- RvcExpander.sv
`timescale 1ns/1ns

module RvcExpander (
    input  logic [15:0] parcel,
    output logic [31:0] expanded,
    output logic        illegal
);

    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rs1C;
    logic [4:0]  rs2C;
    logic [11:0] ciImm;
    logic [10:0] cjOff;

    assign rd = parcel[11:7];
    assign rs2 = parcel[6:2];
    assign rs1C = {2'b01, parcel[9:7]}; // x8..x15.
    assign rs2C = {2'b01, parcel[4:2]};
    assign ciImm = {{7{parcel[12]}}, parcel[6:2]};
    // offset bits 11..1 of c.j and c.jal.
    assign cjOff = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7],
                    parcel[2], parcel[11], parcel[5:3]};

    always_comb begin
        expanded = 32'h0;
        illegal = 1'b0;
        case ({parcel[1:0], parcel[15:13]})
            5'b00_000: begin // addi4spn, also catches all-zero parcel.
                expanded = {2'b00, parcel[10:7], parcel[12:11], parcel[5], parcel[6], 2'b00,
                            5'd2, 3'b000, rs2C, 7'b0010011};
                illegal = parcel[12:5] == 8'h00;
            end
            5'b00_010: expanded = {5'b0, parcel[5], parcel[12:10], parcel[6], 2'b00,
                                   rs1C, 3'b010, rs2C, 7'b0000011};
            5'b00_110: expanded = {5'b0, parcel[5], parcel[12], rs2C, rs1C, 3'b010,
                                   parcel[11:10], parcel[6], 2'b00, 7'b0100011};
            5'b01_000: expanded = {ciImm, rd, 3'b000, rd, 7'b0010011};
            5'b01_001: expanded = {cjOff[10], cjOff[9:0], cjOff[10], {8{cjOff[10]}},
                                   5'd1, 7'b1101111};
            5'b01_010: expanded = {ciImm, 5'd0, 3'b000, rd, 7'b0010011};
            5'b01_011: begin
                illegal = {parcel[12], parcel[6:2]} == 6'h00;
                if (rd == 5'd2) begin // addi16sp.
                    expanded = {{3{parcel[12]}}, parcel[4:3], parcel[5], parcel[2], parcel[6],
                                4'b0000, 5'd2, 3'b000, 5'd2, 7'b0010011};
                end else begin
                    expanded = {{15{parcel[12]}}, parcel[6:2], rd, 7'b0110111};
                end
            end
            5'b01_100: begin
                case (parcel[11:10])
                    2'b00: begin
                        expanded = {7'b0000000, rs2, rs1C, 3'b101, rs1C, 7'b0010011};
                        illegal = parcel[12]; // shamt[5] invalid on rv32.
                    end
                    2'b01: begin
                        expanded = {7'b0100000, rs2, rs1C, 3'b101, rs1C, 7'b0010011};
                        illegal = parcel[12];
                    end
                    2'b10: expanded = {ciImm, rs1C, 3'b111, rs1C, 7'b0010011};
                    default: begin
                        illegal = parcel[12]; // subw/addw are rv64 only.
                        case (parcel[6:5])
                            2'b00: expanded = {7'b0100000, rs2C, rs1C, 3'b000, rs1C, 7'b0110011};
                            2'b01: expanded = {7'b0000000, rs2C, rs1C, 3'b100, rs1C, 7'b0110011};
                            2'b10: expanded = {7'b0000000, rs2C, rs1C, 3'b110, rs1C, 7'b0110011};
                            default: expanded = {7'b0000000, rs2C, rs1C, 3'b111, rs1C,
                                                 7'b0110011};
                        endcase
                    end
                endcase
            end
            5'b01_101: expanded = {cjOff[10], cjOff[9:0], cjOff[10], {8{cjOff[10]}},
                                   5'd0, 7'b1101111};
            5'b01_110, 5'b01_111: expanded = {parcel[12], {3{parcel[12]}}, parcel[6:5], parcel[2],
                                              5'd0, rs1C, {2'b00, parcel[13]},
                                              parcel[11:10], parcel[4:3], parcel[12], 7'b1100011};
            5'b10_000: begin
                expanded = {7'b0000000, rs2, rd, 3'b001, rd, 7'b0010011};
                illegal = parcel[12];
            end
            5'b10_010: begin
                expanded = {4'b0000, parcel[3:2], parcel[12], parcel[6:4], 2'b00,
                            5'd2, 3'b010, rd, 7'b0000011};
                illegal = rd == 5'd0;
            end
            5'b10_100: begin
                if (!parcel[12]) begin
                    if (rs2 == 5'd0) begin // jr.
                        expanded = {12'h000, rd, 3'b000, 5'd0, 7'b1100111};
                        illegal = rd == 5'd0;
                    end else begin
                        expanded = {7'b0000000, rs2, 5'd0, 3'b000, rd, 7'b0110011};
                    end
                end else if (rs2 != 5'd0) begin
                    expanded = {7'b0000000, rs2, rd, 3'b000, rd, 7'b0110011};
                end else if (rd == 5'd0) begin
                    expanded = 32'h00100073; // ebreak.
                end else begin
                    expanded = {12'h000, rd, 3'b000, 5'd1, 7'b1100111};
                end
            end
            5'b10_110: expanded = {4'b0000, parcel[8:7], parcel[12], rs2, 5'd2, 3'b010,
                                   parcel[11:9], 2'b00, 7'b0100011};
            default: illegal = 1'b1; // fp forms, reserved, quadrant 3.
        endcase
    end

endmodule

//--- InstrClassifier.sv
`timescale 1ns/1ns

module InstrClassifier (
    input  logic [31:0]             instr,
    input  logic                    isRvc,
    output rvTypesPkg::instrClass_e cls
);

    always_comb begin
        cls = rvTypesPkg::OTHER;
        if (isRvc) begin
            // quadrant and funct3 of the raw parcel.
            case ({instr[1:0], instr[15:13]})
                5'b00_000, 5'b01_000, 5'b01_010, 5'b01_011, 5'b01_100, 5'b10_000: begin
                    cls = rvTypesPkg::ALU;
                end
                5'b00_010, 5'b10_010: cls = rvTypesPkg::LOAD;
                5'b00_110, 5'b10_110: cls = rvTypesPkg::STORE;
                5'b01_001, 5'b01_101: cls = rvTypesPkg::JAL;
                5'b01_110, 5'b01_111: cls = rvTypesPkg::BRANCH;
                5'b10_100: begin
                    if (instr[6:2] != 5'd0) begin
                        cls = rvTypesPkg::ALU; // mv, add.
                    end else if (instr[12] && instr[11:7] == 5'd0) begin
                        cls = rvTypesPkg::SYSTEM;
                    end else begin
                        cls = rvTypesPkg::JALR;
                    end
                end
                default: cls = rvTypesPkg::OTHER;
            endcase
        end else begin
            case (instr[6:0])
                7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: cls = rvTypesPkg::ALU;
                7'b0000011: cls = rvTypesPkg::LOAD;
                7'b0100011: cls = rvTypesPkg::STORE;
                7'b1100011: cls = rvTypesPkg::BRANCH;
                7'b1101111: cls = rvTypesPkg::JAL;
                7'b1100111: cls = rvTypesPkg::JALR;
                7'b1110011: cls = rvTypesPkg::SYSTEM;
                default:    cls = rvTypesPkg::OTHER; // fence and the rest.
            endcase
        end
    end

endmodule

//--- DecodeMerge.sv
`timescale 1ns/1ns

module DecodeMerge (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mispred,
    input  rvTypesPkg::pdInstr_t    pdSlots[frontendCfgPkg::NUM_OUT],
    input  logic [31:0]             expanded[frontendCfgPkg::NUM_OUT],
    input  logic                    illegal[frontendCfgPkg::NUM_OUT],
    input  rvTypesPkg::instrClass_e cls[frontendCfgPkg::NUM_OUT],
    output logic                    outEn,
    output logic                    outValid,
    input  logic                    outReady,
    output rvTypesPkg::decInstr_t   decSlots[frontendCfgPkg::NUM_OUT]
);

    rvTypesPkg::decInstr_t merged[frontendCfgPkg::NUM_OUT];
    rvTypesPkg::decInstr_t groups[2][frontendCfgPkg::NUM_OUT];

    logic       wrPtr;
    logic       rdPtr;
    logic [1:0] count;
    logic [1:0] countNext;
    logic [1:0] pending;
    logic       push;
    logic       pop;

    always_comb begin
        push = 1'b0;
        for (int i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin
            merged[i].instr = pdSlots[i].isRvc ? expanded[i] : pdSlots[i].instr;
            merged[i].pc = pdSlots[i].pc;
            merged[i].cls = cls[i];
            merged[i].isRvc = pdSlots[i].isRvc;
            merged[i].illegal = pdSlots[i].isRvc && illegal[i];
            merged[i].branchId = pdSlots[i].branchId;
            merged[i].branchPred = pdSlots[i].branchPred;
            merged[i].valid = pdSlots[i].valid;
            push = push | pdSlots[i].valid;
        end
    end

    assign pop = outValid && outReady;
    assign countNext = count + {1'b0, push} - {1'b0, pop};
    assign pending = countNext + {1'b0, outEn}; // a group may still be in flight.
    assign outValid = count != 2'd0;
    assign decSlots = groups[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            groups[wrPtr] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            count <= 2'd0;
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            outEn <= 1'b0;
        end else begin
            count <= countNext;
            wrPtr <= wrPtr ^ push;
            rdPtr <= rdPtr ^ pop;
            outEn <= pending < 2'd2;
        end
    end

endmodule

//--- FetchDecode.sv
`timescale 1ns/1ns

module FetchDecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mispred,
    input  logic                   fetchValid,
    input  rvTypesPkg::halfEntry_t fetchHalves[frontendCfgPkg::NUM_IN],
    output logic                   full,
    output logic                   outValid,
    input  logic                   outReady,
    output rvTypesPkg::decInstr_t  decSlots[frontendCfgPkg::NUM_OUT]
);

    rvTypesPkg::pdInstr_t    pdSlots[frontendCfgPkg::NUM_OUT];
    logic [31:0]             expWord[frontendCfgPkg::NUM_OUT];
    logic                    expIllegal[frontendCfgPkg::NUM_OUT];
    rvTypesPkg::instrClass_e slotCls[frontendCfgPkg::NUM_OUT];
    logic                    outEn;

    PreDecode preDecode (
        .clk(clk),
        .rst(rst),
        .mispred(mispred),
        .fetchValid(fetchValid),
        .fetchHalves(fetchHalves),
        .outEn(outEn),
        .full(full),
        .pdSlots(pdSlots)
    );

    // expander and classifier run side by side per slot.
    for (genvar i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin : slotGen
        RvcExpander rvcExpander (
            .parcel(pdSlots[i].instr[15:0]),
            .expanded(expWord[i]),
            .illegal(expIllegal[i])
        );

        InstrClassifier instrClassifier (
            .instr(pdSlots[i].instr),
            .isRvc(pdSlots[i].isRvc),
            .cls(slotCls[i])
        );
    end

    DecodeMerge decodeMerge (
        .clk(clk),
        .rst(rst),
        .mispred(mispred),
        .pdSlots(pdSlots),
        .expanded(expWord),
        .illegal(expIllegal),
        .cls(slotCls),
        .outEn(outEn),
        .outValid(outValid),
        .outReady(outReady),
        .decSlots(decSlots)
    );

endmodule

//--- FetchDecodeTb.sv
`timescale 1ns/1ns

module FetchDecodeTb;

    typedef struct packed {
        logic [31:0]             raw;
        logic                    isRvc;
        logic [31:0]             exp;
        rvTypesPkg::instrClass_e cls;
        logic                    ill;
    } entry_t;

    logic clk;
    logic rst;
    logic mispred;
    logic fetchValid;
    logic outReady;
    logic full;
    logic outValid;
    rvTypesPkg::halfEntry_t fetchHalves[frontendCfgPkg::NUM_IN];
    rvTypesPkg::decInstr_t  decSlots[frontendCfgPkg::NUM_OUT];
    rvTypesPkg::decInstr_t  heldSlots[frontendCfgPkg::NUM_OUT];

    entry_t                 stimTable[$];
    rvTypesPkg::halfEntry_t stream[$];
    rvTypesPkg::decInstr_t  expected[$];
    int unsigned            lcgState = 68;
    logic                   acceptOn;
    logic                   holdValid;
    logic                   sawFull;

    FetchDecode DUT (
        .clk(clk),
        .rst(rst),
        .mispred(mispred),
        .fetchValid(fetchValid),
        .fetchHalves(fetchHalves),
        .full(full),
        .outValid(outValid),
        .outReady(outReady),
        .decSlots(decSlots)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic checkInstr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) reportMismatch($sformatf("%s instr %h, expected %h", what, got, exp));
    endtask

    task automatic checkClass(input rvTypesPkg::instrClass_e got,
                              input rvTypesPkg::instrClass_e exp);
        if (got !== exp) reportMismatch($sformatf("class %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic checkTags(input rvTypesPkg::decInstr_t got, input rvTypesPkg::decInstr_t exp);
        if (got.pc !== exp.pc || got.branchId !== exp.branchId
                || got.branchPred !== exp.branchPred) begin
            reportMismatch($sformatf("tags pc %h id %h pred %b, expected pc %h id %h pred %b",
                got.pc, got.branchId, got.branchPred, exp.pc, exp.branchId, exp.branchPred));
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) reportMismatch($sformatf("%s flag %b, expected %b", what, got, exp));
    endtask

    task automatic addEntry(input logic isRvc, input logic [31:0] raw, input logic [31:0] exp,
                            input rvTypesPkg::instrClass_e cls, input logic ill);
        stimTable.push_back(entry_t'{raw, isRvc, exp, cls, ill});
    endtask

    // halves get consecutive pcs, tags follow the pc of each half.
    task automatic buildStream(input logic [31:0] basePc, input bit withExpect);
        rvTypesPkg::halfEntry_t h;
        rvTypesPkg::decInstr_t e;
        logic [31:0] pc;
        pc = basePc;
        foreach (stimTable[k]) begin
            e = '0;
            e.pc = pc;
            e.instr = stimTable[k].exp;
            e.cls = stimTable[k].cls;
            e.isRvc = stimTable[k].isRvc;
            e.illegal = stimTable[k].ill;
            e.valid = 1'b1;
            for (int j = 0; j < (stimTable[k].isRvc ? 1 : 2); j++) begin
                h.parcel = j == 0 ? stimTable[k].raw[15:0] : stimTable[k].raw[31:16];
                h.pc = pc;
                h.branchId = pc[4:1];
                h.branchPred = pc[1];
                h.valid = 1'b1;
                stream.push_back(h);
                e.branchId = h.branchId; // last half wins.
                e.branchPred = h.branchPred;
                pc = pc + 32'd2;
            end
            if (withExpect) expected.push_back(e);
        end
    endtask

    // packets only while full is low, with random gaps.
    task automatic feedStream(input int maxCycles);
        int cycles;
        cycles = 0;
        while (stream.size() != 0 && cycles < maxCycles) begin
            @(negedge clk);
            cycles++;
            fetchValid = 1'b0;
            if (!full && nextRand() % 4 != 0) begin
                fetchValid = 1'b1;
                for (int i = 0; i < frontendCfgPkg::NUM_IN; i++) begin
                    fetchHalves[i] = stream.size() != 0 ? stream.pop_front() : '0;
                end
            end
        end
        @(negedge clk);
        fetchValid = 1'b0;
        stream.delete();
    endtask

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        rvTypesPkg::decInstr_t e;
        logic ready;
        if (!rst) begin
            if (full) sawFull = 1'b1;
            if (holdValid && outValid) begin
                for (int i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin
                    checkInstr(decSlots[i].instr, heldSlots[i].instr, "stalled");
                    checkTags(decSlots[i], heldSlots[i]);
                end
            end
            ready = acceptOn && nextRand() % 3 != 0;
            outReady = ready;
            holdValid = outValid && !ready;
            heldSlots = decSlots;
            if (outValid && ready) begin
                for (int i = 0; i < frontendCfgPkg::NUM_OUT; i++) begin
                    if (decSlots[i].valid) begin
                        if (expected.size() == 0) begin
                            reportMismatch($sformatf("unexpected instr %h", decSlots[i].instr));
                        end
                        e = expected.pop_front();
                        if (!e.illegal) checkInstr(decSlots[i].instr, e.instr, "accepted");
                        checkClass(decSlots[i].cls, e.cls);
                        checkTags(decSlots[i], e);
                        checkFlag(decSlots[i].isRvc, e.isRvc, "isRvc");
                        checkFlag(decSlots[i].illegal, e.illegal, "illegal");
                    end
                end
            end
        end
    end

    initial begin
        longint limit;
        #1;
        limit = longint'(stimTable.size()) * 40 * 3 * 100;
        #(limit);
        $display("watchdog timeout, output stalled with %0d instructions pending",
                 expected.size());
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst = 1'b1;
        mispred = 1'b0;
        fetchValid = 1'b0;
        outReady = 1'b0;
        fetchHalves = '{default: '0};
        acceptOn = 1'b0;
        holdValid = 1'b0;
        sawFull = 1'b0;
        addEntry(1, 32'h0040, 32'h00410413, rvTypesPkg::ALU, 0);
        addEntry(0, 32'h00812283, 32'h00812283, rvTypesPkg::LOAD, 0);
        addEntry(1, 32'h4044, 32'h00442483, rvTypesPkg::LOAD, 0);
        addEntry(1, 32'hC404, 32'h00942423, rvTypesPkg::STORE, 0);
        addEntry(1, 32'h157D, 32'hFFF50513, rvTypesPkg::ALU, 0);
        addEntry(0, 32'h00512623, 32'h00512623, rvTypesPkg::STORE, 0);
        addEntry(1, 32'h6605, 32'h00001637, rvTypesPkg::ALU, 0);
        addEntry(0, 32'h00208863, 32'h00208863, rvTypesPkg::BRANCH, 0); // split packet.
        addEntry(1, 32'h6141, 32'h01010113, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h2021, 32'h008000EF, rvTypesPkg::JAL, 0);
        addEntry(1, 32'hBFF5, 32'hFFDFF06F, rvTypesPkg::JAL, 0);
        addEntry(1, 32'hC011, 32'h00040263, rvTypesPkg::BRANCH, 0);
        addEntry(1, 32'hFCFD, 32'hFE049FE3, rvTypesPkg::BRANCH, 0);
        addEntry(0, 32'h00008067, 32'h00008067, rvTypesPkg::JALR, 0);
        addEntry(1, 32'h800D, 32'h00345413, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h9979, 32'hFFE57513, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h8C05, 32'h40940433, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h52F5, 32'hFFD00293, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h8491, 32'h4044D493, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h8C25, 32'h00944433, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h8C45, 32'h00946433, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h8C65, 32'h00947433, rvTypesPkg::ALU, 0);
        addEntry(0, 32'h00000073, 32'h00000073, rvTypesPkg::SYSTEM, 0);
        addEntry(1, 32'h050A, 32'h00251513, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h4592, 32'h00412583, rvTypesPkg::LOAD, 0);
        addEntry(1, 32'hC42E, 32'h00B12423, rvTypesPkg::STORE, 0);
        addEntry(1, 32'h8082, 32'h00008067, rvTypesPkg::JALR, 0);
        addEntry(1, 32'h9282, 32'h000280E7, rvTypesPkg::JALR, 0);
        addEntry(1, 32'h852E, 32'h00B00533, rvTypesPkg::ALU, 0);
        addEntry(1, 32'h9002, 32'h00100073, rvTypesPkg::SYSTEM, 0);
        addEntry(1, 32'h0000, 32'h0, rvTypesPkg::ALU, 1);
        addEntry(1, 32'h2000, 32'h0, rvTypesPkg::OTHER, 1); // fld form.
        addEntry(1, 32'h6181, 32'h0, rvTypesPkg::ALU, 1);
        addEntry(0, 32'h002081B3, 32'h002081B3, rvTypesPkg::ALU, 0);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        buildStream(32'h1000, 1);
        // back end held off until the buffer reports full.
        fork
            feedStream(1 << 30);
            begin
                wait (sawFull);
                acceptOn = 1'b1;
            end
        join
        while (expected.size() != 0) @(negedge clk);
        // back end stalled, fetch runs into full, then the flush.
        acceptOn = 1'b0;
        sawFull = 1'b0;
        buildStream(32'h2000, 0);
        feedStream(3 * stimTable.size());
        if (!sawFull) begin
            $display("full never rose while the back end was stalled");
            $display("CHECKS FAILED");
            $fatal(1, "no back-pressure");
        end
        mispred = 1'b1;
        @(negedge clk);
        mispred = 1'b0;
        acceptOn = 1'b1;
        buildStream(32'h3000, 1);
        feedStream(1 << 30);
        while (expected.size() != 0) @(negedge clk);
        repeat (10) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- fetchDecode.f
rvTypesPkg.sv
frontendCfgPkg.sv
PreDecode.sv
RvcExpander.sv
InstrClassifier.sv
DecodeMerge.sv
FetchDecode.sv
FetchDecodeTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= FetchDecodeTb
FLIST ?= fetchDecode.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing

SOURCES := $(shell cat $(FLIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
